//--- build.f
hdl/psram_pkg.sv
hdl/psram_ctrl.sv
hdl/spi_shifter.sv
hdl/psram_top.sv
sim/psram_model.sv
sim/psram_tb.sv

//--- hdl/psram_ctrl.sv
// PSRAM control FSM: power-up wait, reset-enable/reset sequence,
// single-byte request acceptance and frame issue to the SPI shifter
`timescale 1ns/10ps
`default_nettype none

module psram_ctrl import psram_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        start,		// level, begins init
	input  wire        cmd_strobe,		// one-cycle request pulse
	input  psram_cmd_t cmd,
	input  wire        frame_done,		// from shifter
	input  wire  [7:0] rx_byte,
	output spi_frame_t frame,
	output logic       frame_go,
	output logic       ready,
	output logic       busy,
	output logic       rd_valid,
	output logic [7:0] rd_data
);

	ctrl_state_e state;
	logic [15:0] pu_cnt;			// power-up wait counter
	psram_cmd_t  cmd_q;			// the one accepted request
	logic        accept;
	logic        rd_done;

	// only S_READY has ready high and busy low
	assign accept  = (state == S_READY) && cmd_strobe;
	assign rd_done = (state == S_WAIT_FRAME) && frame_done && !cmd_q.is_write;

	// frame contents follow the state, shifter latches them on frame_go
	always_comb begin
		frame.addr = 24'h000000;
		frame.data = 8'h00;
		case (state)
			S_RSTEN: begin
				frame.kind   = FK_CMD;
				frame.opcode = OP_RSTEN;
			end
			S_RST: begin
				frame.kind   = FK_CMD;
				frame.opcode = OP_RST;
			end
			default: begin
				frame.kind   = cmd_q.is_write ? FK_WRITE : FK_READ;
				frame.opcode = cmd_q.is_write ? OP_WRITE : OP_READ;
				frame.addr   = {1'b0, cmd_q.addr};	// pad to 24 bits
				frame.data   = cmd_q.wdata;		// ignored on reads
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_IDLE_OFF;
			pu_cnt   <= 16'd0;
			frame_go <= 1'b0;
			ready    <= 1'b0;
			busy     <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			frame_go <= 1'b0;			// pulses by default
			rd_valid <= 1'b0;
			case (state)
				S_IDLE_OFF: begin
					pu_cnt <= 16'd0;
					if (start)
						state <= S_POWERUP;
				end
				S_POWERUP: begin
					pu_cnt <= pu_cnt + 16'd1;
					if (pu_cnt == POWERUP_CYCLES - 16'd1) begin
						state    <= S_RSTEN;	// frame picks RSTEN from state
						frame_go <= 1'b1;
					end
				end
				S_RSTEN: begin
					if (frame_done) begin
						state    <= S_RST;
						frame_go <= 1'b1;	// back-to-back reset
					end
				end
				S_RST: begin
					if (frame_done) begin
						state <= S_READY;
						ready <= 1'b1;		// device initialized
					end
				end
				S_READY: begin
					if (accept) begin
						state    <= S_WAIT_FRAME;
						busy     <= 1'b1;
						frame_go <= 1'b1;
					end
				end
				S_WAIT_FRAME: begin
					if (frame_done) begin
						state    <= S_READY;
						busy     <= 1'b0;
						rd_valid <= !cmd_q.is_write;
					end
				end
				default: state <= S_IDLE_OFF;
			endcase
		end
	end

	// request and read data registers
	always_ff @(posedge clk) begin
		if (accept)
			cmd_q <= cmd;
		if (rd_done)
			rd_data <= rx_byte;		// valid with rd_valid
	end

	// frame_go only on entry to a frame-issuing state
	a_go_on_entry: assert property (@(posedge clk) disable iff (!rst_n)
		frame_go |-> (state != $past(state)) &&
			(state inside {S_RSTEN, S_RST, S_WAIT_FRAME}));

	// init is one-way until reset
	a_ready_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		ready |=> ready);

endmodule

`default_nettype wire

//--- hdl/psram_pkg.sv
// opcode, FSM state and frame kind enums for the SPI PSRAM controller
// user request and SPI frame structs, power-up and chip-select timing
`default_nettype none

package psram_pkg;

	localparam logic [15:0] POWERUP_CYCLES = 16'd12800;	// 50 x 256, ~150 us at 84 MHz
	localparam logic [1:0] CE_HIGH_CYCLES = 2'd2;		// ce_n high time between frames
	localparam int ADDR_W = 23;				// 64 Mbit, byte addressed
	localparam logic [5:0] CMD_BITS = 6'd8;			// opcode only
	localparam logic [5:0] LONG_BITS = 6'd40;		// opcode + addr + data

	typedef enum logic [7:0] {
		OP_WRITE = 8'h02,
		OP_READ  = 8'h03,
		OP_RSTEN = 8'h66,	// reset enable, must precede OP_RST
		OP_RST   = 8'h99
	} psram_op_e;

	typedef enum logic [2:0] {
		S_IDLE_OFF   = 3'd0,	// waiting for start
		S_POWERUP    = 3'd1,
		S_RSTEN      = 3'd2,
		S_RST        = 3'd3,
		S_READY      = 3'd4,
		S_WAIT_FRAME = 3'd5	// user request on the wire
	} ctrl_state_e;

	typedef enum logic [1:0] {
		FK_CMD   = 2'd0,	// 8 bits out
		FK_WRITE = 2'd1,	// 40 bits out
		FK_READ  = 2'd2		// 32 out, 8 in
	} frame_kind_e;

	typedef struct packed {
		logic              is_write;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        wdata;
	} psram_cmd_t;

	typedef struct packed {
		frame_kind_e kind;
		psram_op_e   opcode;
		logic [23:0] addr;	// msb always zero
		logic [7:0]  data;
	} spi_frame_t;

endpackage

`default_nettype wire

//--- hdl/psram_top.sv
// PSRAM controller top: control FSM plus SPI shifter
`timescale 1ns/10ps
`default_nettype none

module psram_top import psram_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        start,
	input  wire        cmd_strobe,
	input  psram_cmd_t cmd,
	input  wire        mem_miso,
	output logic       ready,
	output logic       busy,
	output logic       rd_valid,
	output logic [7:0] rd_data,
	output logic       mem_ce_n,
	output logic       mem_clk,
	output logic       mem_mosi
);

	spi_frame_t frame;		// ctrl to shifter
	logic       frame_go;
	logic       frame_done;
	logic [7:0] rx_byte;

	psram_ctrl ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.frame_done (frame_done),
		.rx_byte    (rx_byte),
		.frame      (frame),
		.frame_go   (frame_go),
		.ready      (ready),
		.busy       (busy),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

	spi_shifter shifter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.frame      (frame),
		.frame_go   (frame_go),
		.mem_miso   (mem_miso),
		.frame_done (frame_done),
		.rx_byte    (rx_byte),
		.mem_ce_n   (mem_ce_n),
		.mem_clk    (mem_clk),
		.mem_mosi   (mem_mosi)
	);

endmodule

`default_nettype wire

//--- hdl/spi_shifter.sv
// SPI frame shifter serializing opcode, addr and data msb first
// with mem_clk at clk/2, mem_ce_n timing and read byte capture
`timescale 1ns/10ps
`default_nettype none

module spi_shifter import psram_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  spi_frame_t frame,
	input  wire        frame_go,		// one-cycle pulse only when idle
	input  wire        mem_miso,
	output logic       frame_done,
	output logic [7:0] rx_byte,
	output logic       mem_ce_n,
	output logic       mem_clk,
	output logic       mem_mosi
);

	logic        active;		// ce_n low with bits on the wire
	logic [39:0] sh_reg;
	logic [5:0]  bit_cnt;		// bits still to finish
	logic [1:0]  ce_cnt;		// ce_n high hold countdown
	logic        is_rd;
	logic [39:0] load_sh;
	logic [5:0]  load_bits;
	logic        last_bit;

	// shift pattern and length per frame kind
	always_comb begin
		case (frame.kind)
			FK_WRITE: begin
				load_sh   = {frame.opcode, frame.addr, frame.data};
				load_bits = LONG_BITS;
			end
			FK_READ: begin
				load_sh   = {frame.opcode, frame.addr, 8'h00};	// mosi low in data phase
				load_bits = LONG_BITS;
			end
			default: begin
				load_sh   = {frame.opcode, 32'h0};
				load_bits = CMD_BITS;
			end
		endcase
	end

	assign last_bit = (bit_cnt == 6'd1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active     <= 1'b0;
			bit_cnt    <= 6'd0;
			ce_cnt     <= 2'd0;
			frame_done <= 1'b0;
			mem_ce_n   <= 1'b1;
			mem_clk    <= 1'b0;
			mem_mosi   <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (frame_go) begin
				active   <= 1'b1;
				bit_cnt  <= load_bits;
				mem_ce_n <= 1'b0;
				mem_mosi <= load_sh[39];	// first bit ahead of first rise
			end else if (active) begin
				mem_clk <= !mem_clk;
				if (mem_clk) begin		// falling edge shifts next bit out
					bit_cnt  <= bit_cnt - 6'd1;
					mem_mosi <= last_bit ? 1'b0 : sh_reg[38];
					if (last_bit) begin
						active   <= 1'b0;
						mem_ce_n <= 1'b1;
						ce_cnt   <= CE_HIGH_CYCLES;
					end
				end
			end else if (ce_cnt != 2'd0) begin
				ce_cnt     <= ce_cnt - 2'd1;
				frame_done <= (ce_cnt == 2'd1);	// end of ce_n high time
			end
		end
	end

	// shift register and read byte capture
	always_ff @(posedge clk) begin
		if (frame_go) begin
			sh_reg <= load_sh;
			is_rd  <= (frame.kind == FK_READ);
		end else if (active) begin
			if (mem_clk)
				sh_reg <= {sh_reg[38:0], 1'b0};
			else if (is_rd && bit_cnt <= 6'd8)
				rx_byte <= {rx_byte[6:0], mem_miso};	// sample at rising edge
		end
	end

	a_clk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ce_n |-> !mem_clk);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the PSRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module psram_tb -f build.f -o psram_sim
./obj_dir/psram_sim > sim.log 2>&1
cat sim.log
if grep -q "Errors found" sim.log; then
	exit 1
fi

//--- sim/psram_model.sv
// behavioral SPI PSRAM: frame decode on mem_clk, 256-byte array, opcode log
`timescale 1ns/10ps
`default_nettype none

module psram_model import psram_pkg::*; (
	input  wire  mem_ce_n,
	input  wire  mem_clk,
	input  wire  mem_mosi,
	output logic mem_miso
);

	logic [7:0]  mem [0:255];	// indexed by low address byte
	logic [39:0] sr;		// incoming bits, msb first
	int          n_bits = 0;	// bits clocked in this frame
	logic [7:0]  op_q = 8'h00;
	logic [7:0]  rd_addr;
	logic [7:0]  op_log [0:255];	// opcode per finished frame
	int          len_log [0:255];	// bit count per finished frame
	int          n_frames = 0;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i * 29) ^ 8'hc3;	// power-on pattern
	end

	// rising mem_clk samples mosi, rising ce_n closes the frame
	always @(posedge mem_clk or posedge mem_ce_n) begin
		if (mem_ce_n) begin
			if (n_bits != 0 && n_frames < 256) begin
				op_log[n_frames] = op_q;
				len_log[n_frames] = n_bits;
				n_frames = n_frames + 1;
			end
			n_bits = 0;
		end else begin
			sr = {sr[38:0], mem_mosi};
			n_bits = n_bits + 1;
			if (n_bits == 8)
				op_q = sr[7:0];			// opcode complete
			if (n_bits == 32)
				rd_addr = sr[7:0];		// low address byte
			if (n_bits == 40 && op_q == OP_WRITE)
				mem[sr[15:8]] = sr[7:0];
		end
	end

	// read data out after each falling edge, msb first
	always @(negedge mem_clk) begin
		if (!mem_ce_n && op_q == OP_READ && n_bits >= 32 && n_bits < 40)
			mem_miso <= mem[rd_addr][39 - n_bits];
		else
			mem_miso <= 1'b0;
	end

endmodule

`default_nettype wire

//--- sim/psram_tb.sv
// testbench for the PSRAM controller: clock, reset, request stimulus,
// shadow-array read reference, rd_valid checker and cycle timeout
`timescale 1ns/10ps
`default_nettype none

module psram_tb import psram_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 40000;	// power-up + 68 requests, with margin

	logic       clk = 1'b0;
	logic       rst_n;
	logic       start;
	logic       cmd_strobe;
	psram_cmd_t cmd;
	logic       ready;
	logic       busy;
	logic       rd_valid;
	logic [7:0] rd_data;
	logic       mem_ce_n;
	logic       mem_clk;
	logic       mem_mosi;
	logic       mem_miso;

	logic [7:0] shadow [0:255];	// expected memory contents
	logic [7:0] exp_q [$];		// expected bytes of issued reads
	logic [7:0] exp_byte;
	integer     seed = 32'he324_0984;
	int         errors = 0;
	int         test_errors = 0;
	int         cycles = 0;
	int         reads_issued = 0;
	int         rd_count = 0;

	psram_top dut_i (.*);
	psram_model mem_i (.*);

	always #4 clk = ~clk;		// 8 ns period

	function automatic logic [7:0] expected_read(input logic [7:0] a);
		return shadow[a];
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;			// inputs change 1 ns after the edge
	endtask

	task automatic report_mismatch(input string sig, input int got, input int exp);
		$display("FAIL t=%0t %s: got %0h expected %0h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors)
			$display("test %s: passed", name);
		else
			$display("test %s: failed, %0d mismatches", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic pulse_strobe(input logic wr, input logic [7:0] a, input logic [7:0] d);
		cmd.is_write = wr;
		cmd.addr = {15'd0, a};
		cmd.wdata = d;
		cmd_strobe = 1'b1;
		tick();
		cmd_strobe = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy)
			tick();
		tick();			// checker sees rd_valid first
	endtask

	// one accepted request, shadow and read queue updated
	task automatic request(input logic wr, input logic [7:0] a, input logic [7:0] d);
		while (!ready || busy)
			tick();
		pulse_strobe(wr, a, d);
		if (!busy)
			report_problem("busy did not rise after an accepted strobe");
		if (wr) begin
			shadow[a] = d;
		end else begin
			exp_q.push_back(expected_read(a));
			reads_issued++;
		end
		wait_idle();
	endtask

	// rd_data compare, sampled mid-cycle
	always @(negedge clk) begin
		if (rd_valid) begin
			rd_count++;
			if (exp_q.size() == 0) begin
				report_problem("rd_valid pulsed with no read pending");
			end else begin
				exp_byte = exp_q.pop_front();
				if (rd_data !== exp_byte)
					report_mismatch("rd_data", int'(rd_data), int'(exp_byte));
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int n;
		int frames0;
		int reads0;
		int rd0;
		logic [31:0] r;

		rst_n = 1'b0;
		start = 1'b0;
		cmd_strobe = 1'b0;
		cmd = '0;
		for (int i = 0; i < 256; i++)
			shadow[i] = 8'(i * 29) ^ 8'hc3;	// model power-on pattern
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// idle until start, then the power-up wait
		repeat (5) tick();
		if (ready !== 1'b0)
			report_mismatch("ready", int'(ready), 0);
		if (mem_ce_n !== 1'b1)
			report_mismatch("mem_ce_n", int'(mem_ce_n), 1);
		if (mem_clk !== 1'b0)
			report_mismatch("mem_clk", int'(mem_clk), 0);
		cmd = '{is_write: 1'b1, addr: 23'h40, wdata: 8'hee};
		start = 1'b1;
		n = 0;
		while (mem_ce_n) begin
			tick();
			n++;
			cmd_strobe = (n == 100);	// before ready, must be dropped
		end
		if (n < int'(POWERUP_CYCLES))
			report_problem($sformatf("mem_ce_n fell %0d cycles after start", n));
		end_test("1 power-up wait");

		// exactly RSTEN then RST before ready
		while (!ready)
			tick();
		if (mem_i.n_frames != 2) begin
			report_mismatch("frame count", mem_i.n_frames, 2);
		end else begin
			if (mem_i.op_log[0] !== 8'h66)
				report_mismatch("opcode 0", int'(mem_i.op_log[0]), 'h66);
			if (mem_i.op_log[1] !== 8'h99)
				report_mismatch("opcode 1", int'(mem_i.op_log[1]), 'h99);
			if (mem_i.len_log[0] != 8 || mem_i.len_log[1] != 8)
				report_problem("reset frames are not 8 bits long");
		end
		end_test("2 reset sequence");

		rd0 = rd_count;
		request(1'b1, 8'h12, 8'ha5);
		request(1'b0, 8'h12, 8'h00);
		if (rd_count != rd0 + 1)
			report_mismatch("rd_valid count", rd_count - rd0, 1);
		end_test("3 write then read");

		rd0 = rd_count;
		reads0 = reads_issued;
		for (int k = 0; k < 64; k++) begin
			r = $random(seed);
			request(r[31], r[7:0], r[15:8]);	// direction, addr, data
		end
		if (rd_count - rd0 != reads_issued - reads0)
			report_mismatch("rd_valid count", rd_count - rd0, reads_issued - reads0);
		if (exp_q.size() != 0)
			report_problem("reads left without an rd_valid pulse");
		end_test("4 random requests");

		// second write while busy, shadow keeps the first
		frames0 = mem_i.n_frames;
		pulse_strobe(1'b1, 8'h33, 8'h5c);
		shadow[8'h33] = 8'h5c;
		tick();
		if (!busy)
			report_problem("busy low during the first write");
		pulse_strobe(1'b1, 8'h33, 8'hc5);
		wait_idle();
		if (mem_i.n_frames != frames0 + 1)
			report_mismatch("frame count", mem_i.n_frames - frames0, 1);
		request(1'b0, 8'h33, 8'h00);
		end_test("5 strobe while busy");

		$display("done: %0d reads, %0d rd_valid pulses, %0d errors",
			reads_issued, rd_count, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
